// ==== common/lcd_defs.svh ====
`ifndef LCD_DEFS_SVH
`define LCD_DEFS_SVH

`define LCD_BYTE_W   8
`define LCD_NIBBLE_W 4
`define I2C_ADDR_W   7

`define LCD_EXP_ADDR 7'h20  // PCF8574 with A2..A0 low

`define LCD_CMD_FUNC_SET   8'h28  // 4-bit bus, 2 lines, 5x8
`define LCD_CMD_DISPLAY_ON 8'h0C  // Display on, cursor off
`define LCD_CMD_CLEAR      8'h01
`define LCD_GREETING_CHAR  8'h41  // 'A'

`define LCD_WAIT_POWER_MS  100
`define LCD_WAIT_RESET1_MS 50
`define LCD_WAIT_RESET_MS  10
`define LCD_WAIT_CMD_MS    1
`define LCD_WAIT_CLEAR_MS  20

`endif

// ==== common/lcd_pkg.sv ====
`include "lcd_defs.svh"

package lcd_pkg;

    typedef enum logic [1:0] {
        WAIT_POWER,
        SEND,
        SETTLE,
        DONE
    } init_state_e;

    typedef enum logic [2:0] {
        IDLE,
        START_BIT,
        ADDR_BITS,
        DATA_BITS,
        ACK_BIT,
        STOP_BIT
    } i2c_state_e;

    typedef struct packed {
        logic                   rs;
        logic                   nibble_only;  // Send the high nibble alone
        logic [`LCD_BYTE_W-1:0] code;
    } lcd_cmd_t;

    // Expander pin image, P7..P0
    typedef struct packed {
        logic [`LCD_NIBBLE_W-1:0] nibble;  // LCD D7..D4
        logic                     backlight;
        logic                     enable;
        logic                     rw;
        logic                     rs;
    } exp_byte_t;

endpackage

// ==== lcd/lcd_init_seq.sv ====
`include "lcd_defs.svh"

module lcd_init_seq
    import lcd_pkg::*;
#(
    parameter int DELAY_UNIT = 100_000
) (
    input  logic     clk,
    input  logic     rst,
    output lcd_cmd_t cmd,
    output logic     cmd_valid,
    input  logic     cmd_ready,
    output logic     init_done
);

    localparam logic [2:0] LAST_STEP = 3'd6;
    localparam int POWER_CYCLES = `LCD_WAIT_POWER_MS * DELAY_UNIT;
    localparam int CNT_W = $clog2(POWER_CYCLES + 1);

    init_state_e      state;
    logic [2:0]       step;
    logic [6:0]       step_ms;
    logic [CNT_W-1:0] delay_cnt;

    // Command table
    always_comb begin
        cmd     = '0;
        step_ms = '0;
        case (step)
            3'd0: begin
                cmd     = '{rs: 1'b0, nibble_only: 1'b1, code: 8'h30};  // Reset nibble 3
                step_ms = 7'(`LCD_WAIT_RESET1_MS);
            end
            3'd1: begin
                cmd     = '{rs: 1'b0, nibble_only: 1'b1, code: 8'h30};
                step_ms = 7'(`LCD_WAIT_RESET_MS);
            end
            3'd2: begin
                cmd     = '{rs: 1'b0, nibble_only: 1'b1, code: 8'h20};  // Switch to 4-bit
                step_ms = 7'(`LCD_WAIT_RESET_MS);
            end
            3'd3: begin
                cmd     = '{rs: 1'b0, nibble_only: 1'b0, code: `LCD_CMD_FUNC_SET};
                step_ms = 7'(`LCD_WAIT_CMD_MS);
            end
            3'd4: begin
                cmd     = '{rs: 1'b0, nibble_only: 1'b0, code: `LCD_CMD_DISPLAY_ON};
                step_ms = 7'(`LCD_WAIT_CMD_MS);
            end
            3'd5: begin
                cmd     = '{rs: 1'b0, nibble_only: 1'b0, code: `LCD_CMD_CLEAR};
                step_ms = 7'(`LCD_WAIT_CLEAR_MS);
            end
            default: begin
                cmd     = '{rs: 1'b1, nibble_only: 1'b0, code: `LCD_GREETING_CHAR};
                step_ms = '0;  // Nothing follows the character
            end
        endcase
    end

    assign cmd_valid = (state == SEND);
    assign init_done = (state == DONE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= WAIT_POWER;
            step      <= '0;
            delay_cnt <= CNT_W'(POWER_CYCLES);
        end else begin
            case (state)
                WAIT_POWER: begin
                    if (delay_cnt == '0)
                        state <= SEND;
                    else
                        delay_cnt <= delay_cnt - 1'b1;
                end
                SEND: begin
                    if (cmd_ready) begin
                        delay_cnt <= CNT_W'(step_ms * DELAY_UNIT);
                        state     <= SETTLE;
                    end
                end
                SETTLE: begin
                    // Count only once the nibble writer has finished the step
                    if (cmd_ready) begin
                        if (delay_cnt != '0) begin
                            delay_cnt <= delay_cnt - 1'b1;
                        end else if (step == LAST_STEP) begin
                            state <= DONE;
                        end else begin
                            step  <= step + 1'b1;
                            state <= SEND;
                        end
                    end
                end
                default: ;  // DONE holds until reset
            endcase
        end
    end

endmodule

// ==== lcd/lcd_nibble_writer.sv ====
`include "lcd_defs.svh"

module lcd_nibble_writer
    import lcd_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  lcd_cmd_t  cmd,
    input  logic      cmd_valid,
    output logic      cmd_ready,
    output logic      start,
    output exp_byte_t wr_byte,
    input  logic      busy,
    input  logic      done
);

    lcd_cmd_t   cmd_q;
    logic       active;
    logic       in_flight;  // Frame handed to the master, waiting for done
    logic [1:0] frame;      // Bit 1 selects low nibble, bit 0 drops E
    logic       last_frame;

    assign cmd_ready  = ~active;
    assign last_frame = cmd_q.nibble_only ? (frame == 2'd1) : (frame == 2'd3);

    always_comb begin
        if (frame[1])
            wr_byte.nibble = cmd_q.code[`LCD_NIBBLE_W-1:0];
        else
            wr_byte.nibble = cmd_q.code[`LCD_BYTE_W-1:`LCD_NIBBLE_W];
        wr_byte.backlight = 1'b1;
        wr_byte.enable    = ~frame[0];
        wr_byte.rw        = 1'b0;
        wr_byte.rs        = cmd_q.rs;
    end

    always_ff @(posedge clk) begin
        if (cmd_valid && cmd_ready)
            cmd_q <= cmd;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active    <= 1'b0;
            in_flight <= 1'b0;
            frame     <= '0;
            start     <= 1'b0;
        end else begin
            start <= 1'b0;
            if (!active) begin
                if (cmd_valid) begin
                    active <= 1'b1;
                    frame  <= '0;
                end
            end else if (!in_flight) begin
                if (!busy) begin
                    start     <= 1'b1;
                    in_flight <= 1'b1;
                end
            end else if (done) begin
                in_flight <= 1'b0;
                frame     <= frame + 1'b1;
                if (last_frame)
                    active <= 1'b0;
            end
        end
    end

endmodule

// ==== i2c/i2c_byte_writer.sv ====
`include "lcd_defs.svh"

module i2c_byte_writer
    import lcd_pkg::*;
#(
    parameter int CLK_DIV = 500
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    input  exp_byte_t wr_byte,
    output logic      busy,
    output logic      done,
    output logic      scl,
    output logic      sda_drive_low,
    input  logic      sda_in
);

    localparam int QUARTER = (CLK_DIV >= 8) ? CLK_DIV / 4 : 2;
    localparam int QW = $clog2(QUARTER);
    localparam logic [`LCD_BYTE_W-1:0] ADDR_BYTE = {`LCD_EXP_ADDR, 1'b0};  // Write

    i2c_state_e    state;
    logic [1:0]    phase;  // Quarter of the SCL period
    logic [QW-1:0] q_cnt;
    logic          tick;
    logic [2:0]    bit_cnt;
    logic          sent_addr;
    exp_byte_t     data_q;
    logic          tx_bit;
    logic          last_ack;
    logic          scl_next;
    logic          sda_low_next;

    assign tick   = (q_cnt == QW'(QUARTER - 1));
    assign tx_bit = sent_addr ? data_q[3'd7 - bit_cnt] : ADDR_BYTE[3'd7 - bit_cnt];

    // Bit slot: SCL low for phases 0-1, high for 2-3; SDA moves at phase 1
    always_comb begin
        scl_next     = phase[1];
        sda_low_next = sda_drive_low;
        case (state)
            IDLE: begin
                scl_next     = 1'b1;
                sda_low_next = 1'b0;
            end
            START_BIT: begin
                scl_next     = 1'b1;
                sda_low_next = 1'b1;  // SDA falls with SCL high
            end
            ADDR_BITS, DATA_BITS: begin
                if (phase == 2'd1)
                    sda_low_next = ~tx_bit;
            end
            ACK_BIT: begin
                if (phase == 2'd1)
                    sda_low_next = 1'b0;  // Release for the slave
            end
            STOP_BIT: begin
                if (phase == 2'd1)
                    sda_low_next = 1'b1;
                else if (phase == 2'd3)
                    sda_low_next = 1'b0;  // SDA rises with SCL high
            end
            default: begin
                scl_next     = 1'b1;
                sda_low_next = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && start)
            data_q <= wr_byte;
        if (state == ACK_BIT && phase == 2'd2 && tick)
            last_ack <= sda_in;  // Sampled, not checked
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state         <= IDLE;
            phase         <= '0;
            q_cnt         <= '0;
            bit_cnt       <= '0;
            sent_addr     <= 1'b0;
            busy          <= 1'b0;
            done          <= 1'b0;
            scl           <= 1'b1;
            sda_drive_low <= 1'b0;
        end else begin
            done          <= 1'b0;
            scl           <= scl_next;
            sda_drive_low <= sda_low_next;
            if (state == IDLE) begin
                q_cnt <= '0;
                phase <= '0;
                if (start) begin
                    busy      <= 1'b1;
                    bit_cnt   <= '0;
                    sent_addr <= 1'b0;
                    state     <= START_BIT;
                end
            end else if (!tick) begin
                q_cnt <= q_cnt + 1'b1;
            end else begin
                q_cnt <= '0;
                phase <= phase + 1'b1;
                case (state)
                    START_BIT: begin
                        if (phase == 2'd1) begin
                            phase <= '0;
                            state <= ADDR_BITS;
                        end
                    end
                    ADDR_BITS, DATA_BITS: begin
                        if (phase == 2'd3) begin
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == 3'd7)
                                state <= ACK_BIT;
                        end
                    end
                    ACK_BIT: begin
                        if (phase == 2'd3) begin
                            if (sent_addr) begin
                                state <= STOP_BIT;
                            end else begin
                                sent_addr <= 1'b1;
                                state     <= DATA_BITS;
                            end
                        end
                    end
                    STOP_BIT: begin
                        if (phase == 2'd3) begin
                            busy  <= 1'b0;
                            done  <= 1'b1;
                            state <= IDLE;
                        end
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

endmodule

// ==== verilog/lcd_i2c_top.sv ====
module lcd_i2c_top
    import lcd_pkg::*;
#(
    parameter int CLK_DIV    = 500,
    parameter int DELAY_UNIT = 100_000
) (
    input  logic clk,
    input  logic rst,
    output logic scl,
    inout  wire  sda,
    output logic init_done
);

    lcd_cmd_t  cmd;
    logic      cmd_valid;
    logic      cmd_ready;
    logic      start;
    exp_byte_t wr_byte;
    logic      busy;
    logic      done;
    logic      sda_drive_low;

    assign sda = sda_drive_low ? 1'b0 : 1'bz;  // Open drain, pulled up off chip

    lcd_init_seq #(
        .DELAY_UNIT(DELAY_UNIT)
    ) u_seq (
        .clk      (clk),
        .rst      (rst),
        .cmd      (cmd),
        .cmd_valid(cmd_valid),
        .cmd_ready(cmd_ready),
        .init_done(init_done)
    );

    lcd_nibble_writer u_nibble (
        .clk      (clk),
        .rst      (rst),
        .cmd      (cmd),
        .cmd_valid(cmd_valid),
        .cmd_ready(cmd_ready),
        .start    (start),
        .wr_byte  (wr_byte),
        .busy     (busy),
        .done     (done)
    );

    i2c_byte_writer #(
        .CLK_DIV(CLK_DIV)
    ) u_i2c (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .wr_byte      (wr_byte),
        .busy         (busy),
        .done         (done),
        .scl          (scl),
        .sda_drive_low(sda_drive_low),
        .sda_in       (sda)
    );

endmodule

// ==== bench/lcd_i2c_assertions.sv ====
module lcd_i2c_assertions (
    input logic clk,
    input logic rst,
    input logic start,
    input logic busy,
    input logic done,
    input logic init_done,
    input logic scl,
    input logic sda_drive_low
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    start_idle: assert property (@(posedge clk) disable iff (rst) start |-> !busy)
        else begin
            fail_count++;
            $error("start pulsed while the master was busy");
        end

    done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else begin
            fail_count++;
            $error("done held high for more than one cycle");
        end

    done_sticky: assert property (@(posedge clk) disable iff (rst) init_done |=> init_done)
        else begin
            fail_count++;
            $error("init_done fell after rising");
        end

    // Bus idle right after reset
    reset_idle: assert property (@(posedge clk) $fell(rst) |-> scl && !sda_drive_low)
        else begin
            fail_count++;
            $error("scl or sda not released after reset");
        end

endmodule

bind lcd_i2c_top lcd_i2c_assertions u_assert (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .busy         (busy),
    .done         (done),
    .init_done    (init_done),
    .scl          (scl),
    .sda_drive_low(sda_drive_low)
);

// ==== bench/lcd_i2c_tb.sv ====
`include "lcd_defs.svh"

module lcd_i2c_tb
    import lcd_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_DIV      = 8;
    localparam int DELAY_UNIT   = 4;
    localparam int N_FRAMES     = 22;
    localparam int DELAY_SUM_MS = `LCD_WAIT_POWER_MS + `LCD_WAIT_RESET1_MS
                                + 2 * `LCD_WAIT_RESET_MS + 2 * `LCD_WAIT_CMD_MS
                                + `LCD_WAIT_CLEAR_MS;
    localparam int BASE_CYCLES  = N_FRAMES * 40 * CLK_DIV + DELAY_SUM_MS * DELAY_UNIT;
    localparam int LIMIT        = BASE_CYCLES + BASE_CYCLES / 5;  // 20 percent margin
    localparam int POWER_CYCLES = `LCD_WAIT_POWER_MS * DELAY_UNIT;

    logic clk;
    logic rst;
    logic scl;
    logic init_done;
    wire  sda;

    logic [`LCD_BYTE_W-1:0] trace_mem [0:2*N_FRAMES-1];
    logic [`LCD_BYTE_W-1:0] addr_bits;
    logic [`LCD_BYTE_W-1:0] data_bits;
    logic prev_scl = 1'b1;
    logic prev_sda = 1'b1;
    logic in_frame = 1'b0;
    logic done_seen = 1'b0;
    int   bit_pos = 0;
    int   cycle = 0;
    int   last_stop_cycle = -1;
    int   frame_cnt = 0;
    int   addr_errors = 0;
    int   frame_errors = 0;
    int   proto_errors = 0;

    pullup (sda);

    lcd_i2c_top #(
        .CLK_DIV   (CLK_DIV),
        .DELAY_UNIT(DELAY_UNIT)
    ) dut (
        .clk      (clk),
        .rst      (rst),
        .scl      (scl),
        .sda      (sda),
        .init_done(init_done)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        if (!rst)
            cycle <= cycle + 1;
    end

    task automatic check_addr(input logic [`LCD_BYTE_W-1:0] got,
                              input logic [`LCD_BYTE_W-1:0] exp);
        if (got !== exp) begin
            addr_errors++;
            $display("Error at %0t: frame %0d address %h, expected %h",
                     $time, frame_cnt, got, exp);
        end
    endtask

    task automatic check_frame(input exp_byte_t got, input exp_byte_t exp);
        if (got !== exp) begin
            frame_errors++;
            $display("Error at %0t: frame %0d data %h (rs %b e %b), expected %h (rs %b e %b)",
                     $time, frame_cnt, got, got.rs, got.enable, exp, exp.rs, exp.enable);
        end
    endtask

    task automatic close_frame();
        // Nine pulses per byte plus the scl rise ahead of the stop
        if (bit_pos != 19) begin
            proto_errors++;
            $display("Error at %0t: frame %0d had %0d scl rising edges, expected 19",
                     $time, frame_cnt, bit_pos);
        end
        if (frame_cnt >= N_FRAMES) begin
            proto_errors++;
            $display("Error at %0t: extra frame %0d beyond the trace", $time, frame_cnt);
        end else begin
            check_addr(addr_bits, trace_mem[2*frame_cnt]);
            check_frame(exp_byte_t'(data_bits), exp_byte_t'(trace_mem[2*frame_cnt+1]));
        end
        frame_cnt++;
    endtask

    initial begin
        $readmemh("bench/lcd_i2c_trace.txt", trace_mem);
        if (trace_mem[2*N_FRAMES-1] === 'x) begin
            proto_errors++;
            $display("The trace file could not be read completely");
        end
    end

    // Bus decoder, sampled mid-cycle where scl and sda are settled
    always @(negedge clk) begin
        if (!rst) begin
            if (prev_scl && scl && prev_sda && !sda) begin  // Start condition
                in_frame = 1'b1;
                bit_pos  = 0;
                if (cycle < POWER_CYCLES) begin
                    proto_errors++;
                    $display("Error at %0t: frame began %0d cycles after reset", $time, cycle);
                end
                if (init_done) begin
                    proto_errors++;
                    $display("Error at %0t: frame began after init_done", $time);
                end
            end else if (prev_scl && scl && !prev_sda && sda && in_frame) begin  // Stop
                in_frame        = 1'b0;
                last_stop_cycle = cycle;
                close_frame();
            end else if (!prev_scl && scl && in_frame) begin
                if (bit_pos < 8)
                    addr_bits = {addr_bits[6:0], sda};
                else if (bit_pos > 8 && bit_pos < 17)
                    data_bits = {data_bits[6:0], sda};
                bit_pos++;  // Positions 8 and 17 are the ack slots
            end
            if (init_done && !done_seen) begin
                done_seen = 1'b1;
                if (in_frame || frame_cnt != N_FRAMES || last_stop_cycle >= cycle) begin
                    proto_errors++;
                    $display("Error at %0t: init_done rose after %0d frames", $time, frame_cnt);
                end
            end else if (done_seen && !init_done) begin
                proto_errors++;
                $display("Error at %0t: init_done fell", $time);
            end
        end
        prev_scl = scl;
        prev_sda = sda;
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        repeat (LIMIT) @(posedge clk);
        if (!done_seen) begin
            proto_errors++;
            $display("Timed out: init_done did not rise within %0d cycles", LIMIT);
        end else if (frame_cnt != N_FRAMES) begin
            proto_errors++;
            $display("Error at %0t: %0d frames seen, expected %0d", $time, frame_cnt, N_FRAMES);
        end
        $display("Errors: address %0d, frame %0d, protocol %0d, assertion %0d",
                 addr_errors, frame_errors, proto_errors, dut.u_assert.fail_count);
        if (addr_errors + frame_errors + proto_errors + dut.u_assert.fail_count == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// ==== bench/lcd_i2c_trace.txt ====
// Expected I2C frames in order: address byte, expander data byte
// Data bits: 7..4 nibble, 3 backlight, 2 E, 1 RW, 0 RS
40 3C
40 38
40 3C
40 38
40 2C
40 28
40 2C
40 28
40 8C
40 88
40 0C
40 08
40 CC
40 C8
40 0C
40 08
40 1C
40 18
40 4D
40 49
40 1D
40 19

// ==== lcd_i2c_top.f ====
+incdir+common
common/lcd_pkg.sv
lcd/lcd_init_seq.sv
lcd/lcd_nibble_writer.sv
i2c/i2c_byte_writer.sv
verilog/lcd_i2c_top.sv
bench/lcd_i2c_assertions.sv
bench/lcd_i2c_tb.sv

// ==== Bender.yml ====
package:
  name: lcd_i2c

export_include_dirs:
  - common

sources:
  - files:
      - common/lcd_pkg.sv
      - lcd/lcd_init_seq.sv
      - lcd/lcd_nibble_writer.sv
      - i2c/i2c_byte_writer.sv
      - verilog/lcd_i2c_top.sv
  - target: test
    files:
      - bench/lcd_i2c_assertions.sv
      - bench/lcd_i2c_tb.sv
